/* dv/alu_unit_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_unit_tb import alu_pkg::*; ();

	localparam int WID = 32;
	localparam int DEPTH = 4;
	localparam int SH_W = $clog2(WID);
	localparam logic [WID-1:0] MINV = {1'b1, {(WID-1){1'b0}}};

	// Ops issued by each test, used for the watchdog budget
	localparam int N_ARITH = 200;
	localparam int N_SHIFT = 5 * (9 + 16);
	localparam int N_THREE = 3 * (4 + 16);
	localparam int N_MUL = 2 * 40;
	localparam int N_DIV = 24 + 6;
	localparam int N_PRESS = 40;
	localparam int N_OPS = N_ARITH + N_SHIFT + N_THREE + N_MUL + N_DIV + N_PRESS;

	logic             clk = 1'b0;
	logic             rst_n;
	logic             in_req;
	logic             in_ack;
	alu_op_t          in_op;
	logic [WID-1:0]   in_a;
	logic [WID-1:0]   in_b;
	logic [WID-1:0]   in_c;
	logic [TAG_W-1:0] in_tag;
	logic             out_req;
	logic             out_ack;
	logic [WID-1:0]   out_data;
	logic             out_dbz;
	logic [TAG_W-1:0] out_tag;

	logic [31:0]        rng_state = 32'h996c3cf1;
	logic [TAG_W-1:0]   next_tag = '0;
	logic [WID+TAG_W:0] expect_q [$];
	int                 checks = 0;
	int                 errors = 0;
	int                 mark_checks = 0;
	int                 mark_errors = 0;
	int                 resp_delay = 1;
	int                 max_ack_wait = 0;

	alu_unit_top #(.WID(WID), .DEPTH(DEPTH)) uut (
		.clk(clk), .rst_n(rst_n),
		.in_req(in_req), .in_ack(in_ack), .in_op(in_op),
		.in_a(in_a), .in_b(in_b), .in_c(in_c), .in_tag(in_tag),
		.out_req(out_req), .out_ack(out_ack),
		.out_data(out_data), .out_dbz(out_dbz), .out_tag(out_tag)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] rand_word();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// Picks one of span consecutive opcodes starting at first
	function automatic alu_op_t pick_op(input alu_op_t first, input int span);
		logic [31:0] r;
		r = rand_word() % 32'(span);
		return alu_op_t'(first + r[3:0]);
	endfunction

	function automatic logic [WID-1:0] edge_value(input int idx);
		if (idx == 0)
			return '0;
		else if (idx == 1)
			return '1;
		return MINV;
	endfunction

	// Expected {dbz, data} for one operation
	function automatic logic [WID:0] model_result(input alu_op_t op,
			input logic [WID-1:0] a, input logic [WID-1:0] b, input logic [WID-1:0] c);
		logic signed [WID-1:0]   sa;
		logic signed [WID-1:0]   sb;
		logic signed [WID-1:0]   sc;
		logic signed [WID-1:0]   pick;
		logic signed [2*WID-1:0] wa;
		logic signed [2*WID-1:0] wb;
		logic signed [2*WID-1:0] prod;
		logic [WID-1:0]          r;
		logic                    z;
		sa = a;
		sb = b;
		sc = c;
		wa = sa;
		wb = sb;
		prod = wa * wb;
		z = 1'b0;
		r = '0;
		case (op)
			OP_ADD:   r = a + b;
			OP_SUB:   r = a - b;
			OP_AND:   r = a & b;
			OP_OR:    r = a | b;
			OP_XOR:   r = a ^ b;
			OP_SHL:   r = a << b[SH_W-1:0];
			OP_SHR:   r = a >> b[SH_W-1:0];
			OP_SRA:   r = sa >>> b[SH_W-1:0];
			OP_SLT:   r = (sa < sb) ? WID'(1) : '0;
			OP_SLTU:  r = (a < b) ? WID'(1) : '0;
			OP_MAX3:
			begin
				pick = sa;
				if (sb > pick)
					pick = sb;
				if (sc > pick)
					pick = sc;
				r = pick;
			end
			OP_MIN3:
			begin
				pick = sa;
				if (sb < pick)
					pick = sb;
				if (sc < pick)
					pick = sc;
				r = pick;
			end
			OP_CMOVZ: r = (a == '0) ? c : b;
			OP_MUL:   r = prod[WID-1:0];
			OP_MULH:  r = prod[2*WID-1:WID];
			OP_DIV:
			begin
				if (b == '0)
				begin
					r = '1;
					z = 1'b1;
				end
				else if (a == MINV && b == '1)
					r = MINV;
				else
					r = sa / sb;
			end
		endcase
		return {z, r};
	endfunction

	task automatic send_op(input alu_op_t op, input logic [WID-1:0] a,
			input logic [WID-1:0] b, input logic [WID-1:0] c);
		int wait_cycles;
		expect_q.push_back({next_tag, model_result(op, a, b, c)});
		@(negedge clk);
		in_op = op;
		in_a = a;
		in_b = b;
		in_c = c;
		in_tag = next_tag;
		in_req = 1'b1;
		wait_cycles = 0;
		do
		begin
			@(negedge clk);
			wait_cycles++;
		end
		while (!in_ack);
		if (wait_cycles > max_ack_wait)
			max_ack_wait = wait_cycles;
		in_req = 1'b0;
		do
			@(negedge clk);
		while (in_ack);
		next_tag = next_tag + 1'b1;
	endtask

	task automatic finish_test(input string name);
		while (expect_q.size() != 0)
			@(negedge clk);
		$display("Test %s: %0d results checked, %0d errors", name,
			checks - mark_checks, errors - mark_errors);
		mark_checks = checks;
		mark_errors = errors;
	endtask

	// ==================================================
	// Result responder and comparison
	// ==================================================

	initial
	begin : responder
		logic [WID+TAG_W:0] exp;
		out_ack = 1'b0;
		forever
		begin
			@(negedge clk);
			if (out_req && !out_ack)
			begin
				repeat (resp_delay) @(negedge clk);
				if (expect_q.size() == 0)
				begin
					$display("At %0t a result with tag %0d arrived when none was expected",
						$time, out_tag);
					errors++;
				end
				else
				begin
					exp = expect_q.pop_front();
					checks++;
					if (out_data !== exp[WID-1:0])
					begin
						$display("MISMATCH at %0t: tag %0d data %h, expected %h",
							$time, exp[WID+TAG_W:WID+1], out_data, exp[WID-1:0]);
						errors++;
					end
					if (out_dbz !== exp[WID])
					begin
						$display("MISMATCH at %0t: tag %0d dbz %b, expected %b",
							$time, exp[WID+TAG_W:WID+1], out_dbz, exp[WID]);
						errors++;
					end
					if (out_tag !== exp[WID+TAG_W:WID+1])
					begin
						$display("MISMATCH at %0t: tag %0d, expected tag %0d",
							$time, out_tag, exp[WID+TAG_W:WID+1]);
						errors++;
					end
				end
				out_ack = 1'b1;
				do
					@(negedge clk);
				while (out_req);
				out_ack = 1'b0;
			end
		end
	end

	initial
	begin : watchdog
		repeat (N_OPS * (WID + 40) + 20) @(posedge clk);
		$display("Watchdog expired with %0d results still outstanding", expect_q.size());
		$display("CHECKS FAILED");
		$finish;
	end

	// ==================================================
	// Test sequence
	// ==================================================

	initial
	begin : main
		alu_op_t        op;
		logic [WID-1:0] v;
		logic [WID-1:0] w;
		rst_n = 1'b0;
		in_req = 1'b0;
		in_op = OP_ADD;
		in_a = '0;
		in_b = '0;
		in_c = '0;
		in_tag = '0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		if (in_ack !== 1'b0 || out_req !== 1'b0)
		begin
			$display("Handshake outputs were not low after reset");
			errors++;
		end

		for (int i = 0; i < N_ARITH; i++)
			send_op(pick_op(OP_ADD, 5), rand_word(), rand_word(), rand_word());
		finish_test("arithmetic and logic");

		for (int k = 0; k < 5; k++)
		begin
			op = alu_op_t'(OP_SHL + 4'(k));
			for (int i = 0; i < 9; i++)
				send_op(op, edge_value(i / 3), edge_value(i % 3), rand_word());
			for (int i = 0; i < 16; i++)
				send_op(op, rand_word(), rand_word(), rand_word());
		end
		finish_test("shifts and compares");

		for (int k = 0; k < 3; k++)
		begin
			op = alu_op_t'(OP_MAX3 + 4'(k));
			v = rand_word();
			w = rand_word();
			send_op(op, v, v, v);
			send_op(op, v, w, w);
			send_op(op, '0, v, w);
			send_op(op, MINV, '1, MINV);
			for (int i = 0; i < 16; i++)
				send_op(op, rand_word(), rand_word(), rand_word());
		end
		finish_test("three-operand");

		// Each product is followed by a single-cycle op to check ordering
		for (int i = 0; i < 40; i++)
		begin
			op = ((rand_word() & 32'd1) != 0) ? OP_MULH : OP_MUL;
			send_op(op, rand_word(), rand_word(), '0);
			send_op(pick_op(OP_ADD, 13), rand_word(), rand_word(), rand_word());
		end
		finish_test("multiply");

		for (int i = 0; i < 24; i++)
		begin
			v = rand_word();
			w = rand_word();
			send_op(OP_DIV, v, $signed(w) >>> w[SH_W-1:0], '0);
		end
		send_op(OP_DIV, rand_word(), '0, '0);
		send_op(OP_DIV, '0, '0, '0);
		send_op(OP_DIV, MINV, '0, '0);
		send_op(OP_DIV, MINV, '1, '0);
		send_op(OP_DIV, MINV, WID'(1), '0);
		send_op(OP_DIV, WID'(-7), WID'(2), '0);
		finish_test("divide");

		// A slow consumer fills the FIFO so that in_ack has to wait
		resp_delay = 30;
		max_ack_wait = 0;
		for (int i = 0; i < N_PRESS; i++)
			send_op(pick_op(OP_ADD, 13), rand_word(), rand_word(), rand_word());
		if (max_ack_wait < 10)
		begin
			$display("in_ack never stalled, the longest wait was %0d cycles", max_ack_wait);
			errors++;
		end
		finish_test("back-pressure");
		resp_delay = 1;

		// Any stray result would show up here
		repeat (50) @(negedge clk);
		$display("Total: %0d results checked, %0d errors", checks, errors);
		if (errors == 0 && expect_q.size() == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/alu_core.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_core import alu_pkg::*; #(
	parameter int WID = 32
) (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           start,
	input  alu_op_t        op,
	input  logic [WID-1:0] a,
	input  logic [WID-1:0] b,
	input  logic [WID-1:0] c,
	output logic [WID-1:0] result,
	output logic           dbz,
	output logic           done
);

	localparam int SH_W = $clog2(WID);

	logic [WID-1:0]          alu_out;
	logic [SH_W-1:0]         shamt;
	logic                    is_mul;
	logic                    is_div;
	logic                    is_single;
	logic signed [2*WID-1:0] prod_s1;
	logic signed [2*WID-1:0] prod_s2;
	logic [1:0]              mul_v;
	logic [1:0]              mul_hi;
	logic [WID-1:0]          div_q;
	logic                    div_dbz;
	logic                    div_done;

	assign shamt = b[SH_W-1:0];
	assign is_mul = (op == OP_MUL) || (op == OP_MULH);
	assign is_div = (op == OP_DIV);
	assign is_single = !is_mul && !is_div;

	// ==================================================
	// Single-cycle path
	// ==================================================

	always_comb
	begin
		alu_out = '0;
		case (op)
			OP_ADD:   alu_out = a + b;
			OP_SUB:   alu_out = a - b;
			OP_AND:   alu_out = a & b;
			OP_OR:    alu_out = a | b;
			OP_XOR:   alu_out = a ^ b;
			OP_SHL:   alu_out = a << shamt;
			OP_SHR:   alu_out = a >> shamt;
			OP_SRA:   alu_out = $signed(a) >>> shamt;
			OP_SLT:   alu_out = {{(WID-1){1'b0}}, $signed(a) < $signed(b)};
			OP_SLTU:  alu_out = {{(WID-1){1'b0}}, a < b};
			OP_MAX3:
			begin
				if ($signed(a) >= $signed(b) && $signed(a) >= $signed(c))
					alu_out = a;
				else if ($signed(b) >= $signed(c))
					alu_out = b;
				else
					alu_out = c;
			end
			OP_MIN3:
			begin
				if ($signed(a) <= $signed(b) && $signed(a) <= $signed(c))
					alu_out = a;
				else if ($signed(b) <= $signed(c))
					alu_out = b;
				else
					alu_out = c;
			end
			OP_CMOVZ: alu_out = (a == '0) ? c : b;
			default:  alu_out = '0;
		endcase
	end

	// ==================================================
	// Multiplier pipeline
	// ==================================================

	// Two product stages here, the result register is the third
	always_ff @(posedge clk)
	begin
		if (start && is_mul)
			prod_s1 <= $signed(a) * $signed(b);
		prod_s2 <= prod_s1;
		mul_hi <= {mul_hi[0], op == OP_MULH};
	end

	alu_divider #(
		.WID(WID)
	) u_div (
		.clk(clk),
		.rst_n(rst_n),
		.start(start && is_div),
		.a(a),
		.b(b),
		.quotient(div_q),
		.dbz(div_dbz),
		.done(div_done)
	);

	// ==================================================
	// Completion
	// ==================================================

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			mul_v <= 2'b00;
			done <= 1'b0;
		end
		else
		begin
			mul_v <= {mul_v[0], start && is_mul};
			done <= (start && is_single) || mul_v[1] || div_done;
		end
	end

	// Only one op is ever in flight, so the three sources never collide
	always_ff @(posedge clk)
	begin
		if (start && is_single)
		begin
			result <= alu_out;
			dbz <= 1'b0;
		end
		else if (mul_v[1])
		begin
			result <= mul_hi[1] ? prod_s2[2*WID-1:WID] : prod_s2[WID-1:0];
			dbz <= 1'b0;
		end
		else if (div_done)
		begin
			result <= div_q;
			dbz <= div_dbz;
		end
	end

endmodule

`default_nettype wire

/* rtl/alu_divider.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_divider #(
	parameter int WID = 32
) (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           start,
	input  logic [WID-1:0] a,
	input  logic [WID-1:0] b,
	output logic [WID-1:0] quotient,
	output logic           dbz,
	output logic           done
);

	localparam int CW = $clog2(WID) + 1;

	logic [WID-1:0] rem;
	logic [WID-1:0] quo;
	logic [WID-1:0] div_mag;
	logic           neg_q;
	logic           zero_div;
	logic [CW-1:0]  cnt;
	logic           running;
	logic           fix;
	logic [WID+1:0] trial;

	// Shift the next dividend bit into the partial remainder and try the subtract
	assign trial = {1'b0, rem, quo[WID-1]} - {2'b00, div_mag};

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			running <= 1'b0;
			fix <= 1'b0;
			done <= 1'b0;
			cnt <= '0;
		end
		else
		begin
			done <= fix;
			fix <= running && (cnt == CW'(1));
			if (start)
			begin
				running <= 1'b1;
				cnt <= CW'(WID);
			end
			else if (running)
			begin
				cnt <= cnt - 1'b1;
				if (cnt == CW'(1))
					running <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			// Work on magnitudes. The most negative value stays 2**(WID-1) unsigned
			quo <= a[WID-1] ? -a : a;
			div_mag <= b[WID-1] ? -b : b;
			rem <= '0;
			neg_q <= a[WID-1] ^ b[WID-1];
			zero_div <= (b == '0);
		end
		else if (running)
		begin
			if (!trial[WID+1])
				rem <= trial[WID-1:0];
			else
				rem <= {rem[WID-2:0], quo[WID-1]};
			quo <= {quo[WID-2:0], ~trial[WID+1]};
		end
		if (fix)
		begin
			quotient <= zero_div ? '1 : (neg_q ? -quo : quo);
			dbz <= zero_div;
		end
	end

endmodule

`default_nettype wire

/* rtl/alu_issue.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_issue import alu_pkg::*; #(
	parameter int WID = 32
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_req,
	output logic             in_ack,
	input  alu_op_t          in_op,
	input  logic [WID-1:0]   in_a,
	input  logic [WID-1:0]   in_b,
	input  logic [WID-1:0]   in_c,
	input  logic [TAG_W-1:0] in_tag,
	input  logic             full,
	output logic             start,
	output alu_op_t          op,
	output logic [WID-1:0]   a,
	output logic [WID-1:0]   b,
	output logic [WID-1:0]   c,
	input  logic             done,
	input  logic [WID-1:0]   result,
	input  logic             dbz,
	output logic             push,
	output logic [WID-1:0]   wr_data,
	output logic             wr_dbz,
	output logic [TAG_W-1:0] wr_tag
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_BUSY,
		S_RELEASE
	} issue_state_t;

	issue_state_t     state;
	logic [TAG_W-1:0] tag_q;
	logic             accept;

	// A full FIFO holds off capture, which holds off in_ack
	assign accept = (state == S_IDLE) && in_req && !full;

	// The result goes straight into the FIFO in the cycle done is seen
	assign push = (state == S_BUSY) && done;
	assign wr_data = result;
	assign wr_dbz = dbz;
	assign wr_tag = tag_q;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= S_IDLE;
			in_ack <= 1'b0;
			start <= 1'b0;
		end
		else
		begin
			start <= accept;
			// The requester may drop in_req while the core is still working
			if (state != S_IDLE && !in_req)
				in_ack <= 1'b0;
			case (state)
				S_IDLE:
					if (accept)
					begin
						in_ack <= 1'b1;
						state <= S_BUSY;
					end
				S_BUSY:
					if (done)
						state <= S_RELEASE;
				default:
					// With in_ack already low, a high in_req is the next request
					if (!in_req || !in_ack)
						state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			op <= in_op;
			a <= in_a;
			b <= in_b;
			c <= in_c;
			tag_q <= in_tag;
		end
	end

endmodule

`default_nettype wire

/* rtl/alu_pkg.sv */
`default_nettype none

// ==================================================
// Shared definitions for the integer execution unit
// ==================================================

package alu_pkg;

	// Width of the tag that travels with each operation.
	// Four bits are enough to cover the FIFO depth plus the op in flight
	localparam int TAG_W = 4;

	// Operation codes seen on the request port
	typedef enum logic [3:0] {
		// Add and subtract wrap modulo 2**WID
		OP_ADD   = 4'd0,
		OP_SUB   = 4'd1,

		// Bitwise logic on a and b
		OP_AND   = 4'd2,
		OP_OR    = 4'd3,
		OP_XOR   = 4'd4,

		// Shifts take their amount from the low bits of b
		OP_SHL   = 4'd5,
		OP_SHR   = 4'd6,
		OP_SRA   = 4'd7,

		// Set-less-than returns 0 or 1 in the low bit
		OP_SLT   = 4'd8,
		OP_SLTU  = 4'd9,

		// Three operand forms, all signed
		OP_MAX3  = 4'd10,
		OP_MIN3  = 4'd11,

		// Select c when a is zero, b otherwise
		OP_CMOVZ = 4'd12,

		// Low and high halves of the signed product,
		// both handled by the pipelined multiplier
		OP_MUL   = 4'd13,
		OP_MULH  = 4'd14,

		// Signed quotient through the iterative divider
		OP_DIV   = 4'd15
	} alu_op_t;

	// Every code is used, so the core decode needs no illegal case

endpackage

`default_nettype wire

/* rtl/alu_unit_top.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_unit_top import alu_pkg::*; #(
	parameter int WID   = 32,
	parameter int DEPTH = 4
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_req,
	output logic             in_ack,
	input  alu_op_t          in_op,
	input  logic [WID-1:0]   in_a,
	input  logic [WID-1:0]   in_b,
	input  logic [WID-1:0]   in_c,
	input  logic [TAG_W-1:0] in_tag,
	output logic             out_req,
	input  logic             out_ack,
	output logic [WID-1:0]   out_data,
	output logic             out_dbz,
	output logic [TAG_W-1:0] out_tag
);

	// Issue to core
	logic             start;
	alu_op_t          op;
	logic [WID-1:0]   a;
	logic [WID-1:0]   b;
	logic [WID-1:0]   c;
	logic             done;
	logic [WID-1:0]   result;
	logic             dbz;

	// Issue to FIFO and FIFO to result port
	logic             push;
	logic [WID-1:0]   wr_data;
	logic             wr_dbz;
	logic [TAG_W-1:0] wr_tag;
	logic             pop;
	logic [WID-1:0]   rd_data;
	logic             rd_dbz;
	logic [TAG_W-1:0] rd_tag;
	logic             full;
	logic             empty;

	alu_issue #(.WID(WID)) u_issue (
		.clk(clk), .rst_n(rst_n),
		.in_req(in_req), .in_ack(in_ack), .in_op(in_op),
		.in_a(in_a), .in_b(in_b), .in_c(in_c), .in_tag(in_tag),
		.full(full), .start(start), .op(op), .a(a), .b(b), .c(c),
		.done(done), .result(result), .dbz(dbz),
		.push(push), .wr_data(wr_data), .wr_dbz(wr_dbz), .wr_tag(wr_tag)
	);

	alu_core #(.WID(WID)) u_core (
		.clk(clk), .rst_n(rst_n), .start(start), .op(op),
		.a(a), .b(b), .c(c), .result(result), .dbz(dbz), .done(done)
	);

	result_fifo #(.WID(WID), .DEPTH(DEPTH)) u_fifo (
		.clk(clk), .rst_n(rst_n),
		.push(push), .wr_data(wr_data), .wr_dbz(wr_dbz), .wr_tag(wr_tag),
		.pop(pop), .rd_data(rd_data), .rd_dbz(rd_dbz), .rd_tag(rd_tag),
		.full(full), .empty(empty)
	);

	result_port #(.WID(WID)) u_port (
		.clk(clk), .rst_n(rst_n), .empty(empty), .pop(pop),
		.rd_data(rd_data), .rd_dbz(rd_dbz), .rd_tag(rd_tag),
		.out_req(out_req), .out_ack(out_ack),
		.out_data(out_data), .out_dbz(out_dbz), .out_tag(out_tag)
	);

endmodule

`default_nettype wire

/* rtl/result_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module result_fifo import alu_pkg::*; #(
	parameter int WID   = 32,
	parameter int DEPTH = 4
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             push,
	input  logic [WID-1:0]   wr_data,
	input  logic             wr_dbz,
	input  logic [TAG_W-1:0] wr_tag,
	input  logic             pop,
	output logic [WID-1:0]   rd_data,
	output logic             rd_dbz,
	output logic [TAG_W-1:0] rd_tag,
	output logic             full,
	output logic             empty
);

	localparam int AW = $clog2(DEPTH);

	logic [WID-1:0]   data_mem [DEPTH];
	logic             dbz_mem  [DEPTH];
	logic [TAG_W-1:0] tag_mem  [DEPTH];
	logic [AW:0]      wr_ptr;
	logic [AW:0]      rd_ptr;

	// The extra pointer bit tells a full buffer from an empty one
	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr == {~rd_ptr[AW], rd_ptr[AW-1:0]});

	assign rd_data = data_mem[rd_ptr[AW-1:0]];
	assign rd_dbz = dbz_mem[rd_ptr[AW-1:0]];
	assign rd_tag = tag_mem[rd_ptr[AW-1:0]];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (push && !full)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop && !empty)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (push && !full)
		begin
			data_mem[wr_ptr[AW-1:0]] <= wr_data;
			dbz_mem[wr_ptr[AW-1:0]] <= wr_dbz;
			tag_mem[wr_ptr[AW-1:0]] <= wr_tag;
		end
	end

endmodule

`default_nettype wire

/* rtl/result_port.sv */
`timescale 1ns/100ps
`default_nettype none

module result_port import alu_pkg::*; #(
	parameter int WID = 32
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             empty,
	output logic             pop,
	input  logic [WID-1:0]   rd_data,
	input  logic             rd_dbz,
	input  logic [TAG_W-1:0] rd_tag,
	output logic             out_req,
	input  logic             out_ack,
	output logic [WID-1:0]   out_data,
	output logic             out_dbz,
	output logic [TAG_W-1:0] out_tag
);

	typedef enum logic [1:0] {
		P_IDLE,
		P_REQ,
		P_RELEASE
	} port_state_t;

	port_state_t state;

	// Take the head only when the previous handshake has fully closed
	assign pop = (state == P_IDLE) && !empty;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= P_IDLE;
			out_req <= 1'b0;
		end
		else
		begin
			case (state)
				P_IDLE:
					if (pop)
					begin
						out_req <= 1'b1;
						state <= P_REQ;
					end
				P_REQ:
					if (out_ack)
					begin
						out_req <= 1'b0;
						state <= P_RELEASE;
					end
				default:
					if (!out_ack)
						state <= P_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (pop)
		begin
			out_data <= rd_data;
			out_dbz <= rd_dbz;
			out_tag <= rd_tag;
		end
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f sources.f --top-module alu_unit_tb \
	-Mdir obj_dir -o alu_sim \
	&& ./obj_dir/alu_sim | tee sim.log \
	&& grep -qx "ALL CHECKS PASSED" sim.log \
	&& echo "run.sh: simulation passed" \
	|| { echo "run.sh: simulation did not pass"; exit 1; }

/* sources.f */
rtl/alu_pkg.sv
rtl/alu_divider.sv
rtl/alu_core.sv
rtl/alu_issue.sv
rtl/result_fifo.sv
rtl/result_port.sv
rtl/alu_unit_top.sv
dv/alu_unit_tb.sv
